// File: hdl/lsq_cfg_pkg.sv
// LSQ side configuration: thread count and thread index width
`default_nettype none

package lsq_cfg_pkg;

    // ============================================================
    // Thread configuration
    // ============================================================

    // Number of LSQ threads sharing the data memory port
    localparam int THREAD_NUM = 4;

    // Bits needed to name one thread
    localparam int THREAD_IDX_W = $clog2(THREAD_NUM);

endpackage : lsq_cfg_pkg

`default_nettype wire

// File: hdl/mem_bus_pkg.sv
// Memory bus definitions: command enum, request and response words, memory geometry
`default_nettype none

package mem_bus_pkg;

    // ============================================================
    // Memory geometry and timing
    // ============================================================

    // Word address, 64 words in total
    localparam int ADDR_W    = 6;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    // Data word width
    localparam int DATA_W = 32;

    // Cycles from acceptance to response
    localparam int MEM_LATENCY = 2;

    // Latency counter also covers the response cycle itself
    localparam int LAT_CNT_W = $clog2(MEM_LATENCY + 2);

    // Response tag, zero means no response this cycle
    localparam int RESP_W = 4;

    // ============================================================
    // Bus words
    // ============================================================

    // Command on the shared port
    typedef enum logic [1:0] {
        BUS_NONE  = 2'b00,
        BUS_LOAD  = 2'b01,
        BUS_STORE = 2'b10
    } bus_cmd_e;

    // One request from a thread
    typedef struct packed {
        bus_cmd_e            command;
        logic [ADDR_W-1:0]   addr;
        // Store data, ignored for loads
        logic [DATA_W-1:0]   data;
    } mem_req_t;

    // One response from memory
    typedef struct packed {
        logic [RESP_W-1:0]   response;
        logic [DATA_W-1:0]   data;
    } mem_rsp_t;

endpackage : mem_bus_pkg

`default_nettype wire

// File: hdl/lsq_rr_arbiter.sv
// Work-conserving round-robin arbiter with grant lock until acknowledge
`default_nettype none

module lsq_rr_arbiter
    import lsq_cfg_pkg::*;
(
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    // Filtered request vector, one bit per thread
    input  wire logic [THREAD_NUM-1:0]   req_i,
    // Memory answered the granted request
    input  wire logic                    ack_i,
    output logic      [THREAD_IDX_W-1:0] grant_o,
    output logic                         valid_o
);

    // ============================================================
    // Helpers
    // ============================================================

    // Next thread index with wrap
    function automatic logic [THREAD_IDX_W-1:0] next_idx(
        input logic [THREAD_IDX_W-1:0] idx
    );
        if (int'(idx) == THREAD_NUM - 1) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    // ============================================================
    // State
    // ============================================================

    // Highest priority thread for the next pick
    logic [THREAD_IDX_W-1:0] ptr_q;
    // Grant is held while locked
    logic                    lock_q;
    logic [THREAD_IDX_W-1:0] lock_idx_q;

    // Combinational pick from the pointer
    logic                    pick_found;
    logic [THREAD_IDX_W-1:0] pick_idx;

    // ============================================================
    // Pick logic
    // ============================================================

    always_comb begin
        pick_found = 1'b0;
        pick_idx   = ptr_q;
        // Walk from the pointer, first requester wins
        for (int off = 0; off < THREAD_NUM; off++) begin
            if (!pick_found && req_i[(int'(ptr_q) + off) % THREAD_NUM]) begin
                pick_found = 1'b1;
                pick_idx   = THREAD_IDX_W'((int'(ptr_q) + off) % THREAD_NUM);
            end
        end
    end

    // Locked index wins over a fresh pick
    assign valid_o = lock_q | pick_found;
    assign grant_o = lock_q ? lock_idx_q : pick_idx;

    // ============================================================
    // Pointer and lock
    // ============================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else if (valid_o && ack_i) begin
            // Served, rotate priority past the winner
            ptr_q  <= next_idx(grant_o);
            lock_q <= 1'b0;
        end else if (!lock_q && pick_found) begin
            // Hold the choice until memory answers
            lock_q     <= 1'b1;
            lock_idx_q <= pick_idx;
        end
    end

endmodule : lsq_rr_arbiter

`default_nettype wire

// File: hdl/dcache_switch.sv
// Data memory switch: store-over-load filtering, grant routing, arbiter acknowledge
`default_nettype none

module dcache_switch
    import lsq_cfg_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    // One request word per thread
    input  wire mem_req_t [THREAD_NUM-1:0] lsq_mem_i,
    // Response from memory
    input  wire mem_rsp_t                 dcache_lsq_i,
    // One-hot grant back to the threads
    output logic          [THREAD_NUM-1:0] dcache_grant_o,
    // Selected request to memory
    output mem_req_t                      lsq_dcache_o
);

    // ============================================================
    // Signals
    // ============================================================

    logic [THREAD_NUM-1:0]   load_req;
    logic [THREAD_NUM-1:0]   store_req;
    logic [THREAD_NUM-1:0]   arb_req;
    logic                    arb_ack;
    logic [THREAD_IDX_W-1:0] grant_idx;
    logic                    grant_valid;

    // ============================================================
    // Arbiter
    // ============================================================

    lsq_rr_arbiter i_lsq_rr_arbiter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (arb_req),
        .ack_i   (arb_ack),
        .grant_o (grant_idx),
        .valid_o (grant_valid)
    );

    // ============================================================
    // Request classes
    // ============================================================

    always_comb begin
        load_req  = '0;
        store_req = '0;
        // Every thread competes, thread 0 included
        for (int t = 0; t < THREAD_NUM; t++) begin
            load_req[t]  = (lsq_mem_i[t].command == BUS_LOAD);
            store_req[t] = (lsq_mem_i[t].command == BUS_STORE);
        end
    end

    // Any pending store masks all loads
    assign arb_req = (store_req != '0) ? store_req : load_req;

    // Tag nonzero on a live grant ends the transaction
    assign arb_ack = grant_valid && (dcache_lsq_i.response != '0);

    // ============================================================
    // Grant routing
    // ============================================================

    always_comb begin
        // Idle port shows no command
        lsq_dcache_o   = '{command: BUS_NONE, addr: '0, data: '0};
        dcache_grant_o = '0;
        if (grant_valid) begin
            lsq_dcache_o   = lsq_mem_i[grant_idx];
            dcache_grant_o = THREAD_NUM'(1) << grant_idx;
        end
    end

endmodule : dcache_switch

`default_nettype wire

// File: hdl/dcache_mem.sv
// Single-port data memory with fixed latency and wrapping response tag
`default_nettype none

module dcache_mem
    import mem_bus_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    // Held granted request from the switch
    input  wire mem_req_t mem_req_i,
    output mem_rsp_t      mem_rsp_o
);

    // ============================================================
    // Storage and state
    // ============================================================

    // Word array
    logic [DATA_W-1:0]    mem_q [MEM_DEPTH];

    // 0 idle, 1..MEM_LATENCY waiting, MEM_LATENCY+1 response cycle
    logic [LAT_CNT_W-1:0] lat_cnt_q;

    // Request captured on acceptance
    bus_cmd_e             cap_cmd_q;
    logic [ADDR_W-1:0]    cap_addr_q;
    logic [DATA_W-1:0]    cap_data_q;

    // Next tag to hand out, never zero
    logic [RESP_W-1:0]    tag_q;

    logic                 accept;
    logic                 rsp_fire;

    // ============================================================
    // Control decode
    // ============================================================

    // Busy includes the response cycle so the held request is not taken twice
    assign accept   = (lat_cnt_q == '0) && (mem_req_i.command != BUS_NONE);
    assign rsp_fire = (lat_cnt_q == LAT_CNT_W'(MEM_LATENCY));

    // ============================================================
    // Storage
    // ============================================================

    always_ff @(posedge clk_i) begin
        // Store writes on acceptance
        if (accept && (mem_req_i.command == BUS_STORE)) begin
            mem_q[mem_req_i.addr] <= mem_req_i.data;
        end
    end

    // Capture registers, payload only
    always_ff @(posedge clk_i) begin
        if (accept) begin
            cap_cmd_q  <= mem_req_i.command;
            cap_addr_q <= mem_req_i.addr;
            cap_data_q <= mem_req_i.data;
        end
    end

    // ============================================================
    // Latency counter, tag and response
    // ============================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lat_cnt_q <= '0;
            tag_q     <= RESP_W'(1);
            mem_rsp_o <= '0;
        end else begin
            // Response lasts a single cycle
            mem_rsp_o.response <= '0;

            if (accept) begin
                lat_cnt_q <= LAT_CNT_W'(1);
            end else if (lat_cnt_q == LAT_CNT_W'(MEM_LATENCY + 1)) begin
                // Response cycle done, back to idle
                lat_cnt_q <= '0;
            end else if (lat_cnt_q != '0) begin
                lat_cnt_q <= lat_cnt_q + 1'b1;
            end

            if (rsp_fire) begin
                mem_rsp_o.response <= tag_q;
                // Stores echo the written word
                if (cap_cmd_q == BUS_STORE) begin
                    mem_rsp_o.data <= cap_data_q;
                end else begin
                    mem_rsp_o.data <= mem_q[cap_addr_q];
                end
                // Skip zero on wrap
                if (tag_q == '1) begin
                    tag_q <= RESP_W'(1);
                end else begin
                    tag_q <= tag_q + 1'b1;
                end
            end
        end
    end

endmodule : dcache_mem

`default_nettype wire

// File: hdl/dcache_subsys.sv
// Data memory subsystem top: switch and memory model
`default_nettype none

module dcache_subsys
    import lsq_cfg_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    // Requests from the LSQ threads, word k from thread k
    input  wire mem_req_t [THREAD_NUM-1:0] lsq_mem_i,
    // One-hot grant to the threads
    output logic          [THREAD_NUM-1:0] dcache_grant_o,
    // Memory response, seen by all threads
    output mem_rsp_t                       dcache_rsp_o
);

    // ============================================================
    // Internal wires
    // ============================================================

    // Granted request on its way to memory
    mem_req_t lsq_dcache;

    // ============================================================
    // Switch
    // ============================================================

    dcache_switch i_dcache_switch (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lsq_mem_i      (lsq_mem_i),
        .dcache_lsq_i   (dcache_rsp_o),
        .dcache_grant_o (dcache_grant_o),
        .lsq_dcache_o   (lsq_dcache)
    );

    // ============================================================
    // Memory model
    // ============================================================

    // Response also feeds the switch for the acknowledge
    dcache_mem i_dcache_mem (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .mem_req_i (lsq_dcache),
        .mem_rsp_o (dcache_rsp_o)
    );

endmodule : dcache_subsys

`default_nettype wire

// File: verif/tb_clk_gen.sv
// Testbench clock and reset generator
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns clock period
    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 3;
    // Release lands a little after the edge
    localparam int RST_DLY     = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #RST_DLY;
        rst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

// File: verif/tb_dcache_subsys.sv
// Testbench top: thread request models, reference memory and arbiter, checks, watchdog
`default_nettype none

module tb_dcache_subsys
    import lsq_cfg_pkg::*;
    import mem_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ============================================================
    // Test lengths and limits
    // ============================================================

    localparam int DRIVE_DLY    = 10;
    localparam int MIX_OPS      = 4 * THREAD_NUM;
    localparam int RR_OPS       = 6 * THREAD_NUM;
    localparam int RAND_OPS     = 12 * THREAD_NUM;
    localparam int TOTAL_OPS    = MEM_DEPTH + 2 + MIX_OPS + RR_OPS + RAND_OPS;
    // Each op costs latency plus grant and ack cycle
    // Idle jobs and gaps come on top
    localparam int WATCHDOG_CYC = TOTAL_OPS * (MEM_LATENCY + 2) + RAND_OPS + 50;

    logic                      clk;
    logic                      rst_n;
    mem_req_t [THREAD_NUM-1:0] lsq_req;
    logic     [THREAD_NUM-1:0] dcache_grant;
    mem_rsp_t                  dcache_rsp;

    // Pending jobs per thread
    // A BUS_NONE job idles one cycle
    mem_req_t          job_q [THREAD_NUM][$];
    int                issue_cyc [THREAD_NUM];

    // Reference memory and arbiter state
    logic [DATA_W-1:0] shadow [MEM_DEPTH];
    int                ref_ptr;
    logic              ref_lock;
    int                ref_idx;
    int                ref_rsp_cyc;
    logic [RESP_W-1:0] ref_tag;
    int                cyc = 0;
    int                rr_prev;
    logic              lone_mode;
    logic              rr_mode;
    logic [31:0]       rng_state;
    int                grant_err = 0;
    int                tag_err = 0;
    int                data_err = 0;
    int                lat_err = 0;

    tb_clk_gen i_tb_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dcache_subsys i_dcache_subsys (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .lsq_mem_i      (lsq_req),
        .dcache_grant_o (dcache_grant),
        .dcache_rsp_o   (dcache_rsp)
    );

    // ============================================================
    // Helpers and reference model
    // ============================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Initial contents depend on every address bit
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return 32'hA5C3_0000 ^ (DATA_W'(addr) * 32'h0104_1041);
    endfunction

    // Stores first, then first candidate at or after the pointer; -1 if none
    function automatic int expected_winner(input mem_req_t [THREAD_NUM-1:0] reqs,
                                           input int ptr);
        logic [THREAD_NUM-1:0] stores;
        logic [THREAD_NUM-1:0] loads;
        logic [THREAD_NUM-1:0] cand;
        for (int k = 0; k < THREAD_NUM; k++) begin
            stores[k] = (reqs[k].command == BUS_STORE);
            loads[k]  = (reqs[k].command == BUS_LOAD);
        end
        cand = (stores != '0) ? stores : loads;
        for (int off = 0; off < THREAD_NUM; off++) begin
            if (cand[(ptr + off) % THREAD_NUM]) begin
                return (ptr + off) % THREAD_NUM;
            end
        end
        return -1;
    endfunction

    // Shadow memory access, gives the word memory should return
    function automatic logic [DATA_W-1:0] ref_access(input mem_req_t r);
        if (r.command == BUS_STORE) begin
            shadow[r.addr] = r.data;
        end
        return shadow[r.addr];
    endfunction

    task automatic push_job(input int k, input bus_cmd_e cmd,
                            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        mem_req_t r;
        r.command = cmd;
        r.addr    = addr;
        r.data    = data;
        job_q[k].push_back(r);
    endtask

    // Until every queue is drained and no thread requests
    task automatic wait_idle();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int k = 0; k < THREAD_NUM; k++) begin
                if (job_q[k].size() != 0 || lsq_req[k].command != BUS_NONE) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    // ============================================================
    // Thread request models
    // ============================================================

    initial begin : thread_models
        logic [THREAD_NUM-1:0] served;
        lsq_req = '0;
        forever begin
            // Served means grant and nonzero tag at the coming edge
            @(negedge clk);
            for (int k = 0; k < THREAD_NUM; k++) begin
                served[k] = (lsq_req[k].command != BUS_NONE) && dcache_grant[k]
                            && (dcache_rsp.response != '0);
            end
            @(posedge clk);
            #DRIVE_DLY;
            for (int k = 0; k < THREAD_NUM; k++) begin
                if (served[k] || lsq_req[k].command == BUS_NONE) begin
                    lsq_req[k] = '0;
                    if (job_q[k].size() != 0) begin
                        lsq_req[k] = job_q[k].pop_front();
                        issue_cyc[k] = cyc + 1;
                    end
                end
            end
        end
    end

    // ============================================================
    // Comparison once per cycle at the falling edge
    // ============================================================

    always @(negedge clk) begin : compare
        int                    pick;
        logic [THREAD_NUM-1:0] store_vec;
        logic [THREAD_NUM-1:0] rot_grant;
        logic [THREAD_NUM-1:0] exp_grant;
        logic [RESP_W-1:0]     exp_tag;
        logic [DATA_W-1:0]     exp_data;
        logic                  rsp_due;
        cyc++;
        if (!rr_mode) begin
            rr_prev = -1;
        end
        if (!rst_n) begin
            ref_ptr  = 0;
            ref_lock = 1'b0;
            ref_tag  = RESP_W'(1);
            // State is unknown until the first rising edge applies reset
            if (cyc > 1) begin
                assert (dcache_grant == '0 && dcache_rsp.response == '0) else begin
                    grant_err++;
                    $display("[FAIL] %0t: grant %b tag %0d during reset", $time,
                             dcache_grant, dcache_rsp.response);
                end
            end
        end else begin
            for (int k = 0; k < THREAD_NUM; k++) begin
                store_vec[k] = (lsq_req[k].command == BUS_STORE);
            end
            // New pick only while the arbiter is idle
            if (!ref_lock) begin
                pick = expected_winner(lsq_req, ref_ptr);
                if (pick >= 0) begin
                    ref_lock    = 1'b1;
                    ref_idx     = pick;
                    ref_rsp_cyc = cyc + MEM_LATENCY + 1;
                    assert (store_vec == '0 || (dcache_grant & ~store_vec) == '0) else begin
                        grant_err++;
                        $display("[FAIL] %0t: load granted over store %b", $time, store_vec);
                    end
                    // Next thread after the previous winner
                    if (rr_mode && rr_prev >= 0) begin
                        rot_grant = THREAD_NUM'(1) << ((rr_prev + 1) % THREAD_NUM);
                        assert (dcache_grant == rot_grant) else begin
                            grant_err++;
                            $display("[FAIL] %0t: rotation broke, grant %b after thread %0d",
                                     $time, dcache_grant, rr_prev);
                        end
                    end
                    if (rr_mode) begin
                        rr_prev = pick;
                    end
                end
            end
            // Grant is held steady through the whole transaction
            exp_grant = ref_lock ? (THREAD_NUM'(1) << ref_idx) : '0;
            assert (dcache_grant == exp_grant) else begin
                grant_err++;
                $display("[FAIL] %0t: grant %b expected %b", $time, dcache_grant, exp_grant);
            end
            rsp_due = ref_lock && (cyc == ref_rsp_cyc);
            exp_tag = rsp_due ? ref_tag : '0;
            assert (dcache_rsp.response == exp_tag) else begin
                tag_err++;
                $display("[FAIL] %0t: tag %0d expected %0d", $time,
                         dcache_rsp.response, exp_tag);
            end
            // Lone thread sees the bare latency
            if (lone_mode && dcache_rsp.response != '0) begin
                assert (cyc - issue_cyc[ref_idx] == MEM_LATENCY + 1) else begin
                    lat_err++;
                    $display("[FAIL] %0t: latency %0d cycles", $time,
                             cyc - issue_cyc[ref_idx]);
                end
            end
            if (rsp_due) begin
                exp_data = ref_access(lsq_req[ref_idx]);
                assert (dcache_rsp.data == exp_data) else begin
                    data_err++;
                    $display("[FAIL] %0t: thread %0d data %h expected %h", $time, ref_idx,
                             dcache_rsp.data, exp_data);
                end
                ref_tag  = (ref_tag == '1) ? RESP_W'(1) : ref_tag + 1'b1;
                ref_ptr  = (ref_idx + 1) % THREAD_NUM;
                ref_lock = 1'b0;
            end
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin : main_seq
        logic [31:0] r;
        rng_state = 32'd15382;
        lone_mode = 1'b0;
        rr_mode   = 1'b0;
        wait (rst_n === 1'b1);
        // First cycle after reset stays quiet
        @(negedge clk);
        // Fill every word, stores spread over the threads
        for (int a = 0; a < MEM_DEPTH; a++) begin
            push_job(a % THREAD_NUM, BUS_STORE, ADDR_W'(a), fill_word(ADDR_W'(a)));
        end
        wait_idle();
        // Single thread, store then load of one word
        lone_mode = 1'b1;
        push_job(1, BUS_STORE, ADDR_W'(37), 32'hDEAD_BEEF);
        push_job(1, BUS_LOAD, ADDR_W'(37), '0);
        wait_idle();
        lone_mode = 1'b0;
        // Lower half loads, upper half stores, all pending together
        for (int i = 0; i < MIX_OPS / THREAD_NUM; i++) begin
            for (int k = 0; k < THREAD_NUM; k++) begin
                rng_state = xorshift32(rng_state);
                push_job(k, (k < THREAD_NUM / 2) ? BUS_LOAD : BUS_STORE,
                         rng_state[ADDR_W-1:0], rng_state);
            end
        end
        wait_idle();
        // Continuous loads from all threads
        rr_mode = 1'b1;
        for (int i = 0; i < RR_OPS / THREAD_NUM; i++) begin
            for (int k = 0; k < THREAD_NUM; k++) begin
                rng_state = xorshift32(rng_state);
                push_job(k, BUS_LOAD, rng_state[ADDR_W-1:0], '0);
            end
        end
        wait_idle();
        rr_mode = 1'b0;
        // Random mix with idle gaps
        for (int i = 0; i < RAND_OPS / THREAD_NUM; i++) begin
            for (int k = 0; k < THREAD_NUM; k++) begin
                rng_state = xorshift32(rng_state);
                r = rng_state;
                if (r[0]) begin
                    push_job(k, BUS_NONE, '0, '0);
                end
                rng_state = xorshift32(rng_state);
                push_job(k, r[1] ? BUS_STORE : BUS_LOAD, r[ADDR_W+1:2], rng_state);
            end
        end
        wait_idle();
        $display("Errors: grant %0d, tag %0d, data %0d, latency %0d",
                 grant_err, tag_err, data_err, lat_err);
        if (grant_err + tag_err + data_err + lat_err == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Hang guard
    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TB FAILED");
        $finish;
    end

endmodule : tb_dcache_subsys

`default_nettype wire

// File: dcache_subsys.f
hdl/lsq_cfg_pkg.sv
hdl/mem_bus_pkg.sv
hdl/lsq_rr_arbiter.sv
hdl/dcache_switch.sv
hdl/dcache_mem.sv
hdl/dcache_subsys.sv
verif/tb_clk_gen.sv
verif/tb_dcache_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dcache subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f dcache_subsys.f \
    --top-module tb_dcache_subsys \
    -o tb_dcache_subsys

./obj_dir/tb_dcache_subsys > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
